//--- build.f
design/cache_pkg.sv
design/line_word_counter.sv
design/slot_tag_store.sv
design/line_data_ram.sv
design/cache_ctrl_fsm.sv
design/page_cache_top.sv
verification/tb_clock_gen.sv
verification/cache_checker.sv
verification/page_cache_tb.sv

//--- design/cache_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl_fsm #(
  parameter int SLOT_COUNT = 4,
  parameter int LINE_WORDS = 16,
  localparam int OFF_W  = $clog2(LINE_WORDS),
  localparam int PAGE_W = cache_pkg::ADDR_W - OFF_W
) (
  input  wire                          clk,
  input  wire                          sys_rst_n,
  input  cache_pkg::host_req_t         host_req,
  output logic [cache_pkg::DATA_W-1:0] readdata,
  output logic                         waitrequest,
  input  wire [SLOT_COUNT-1:0]         hit_vec,
  input  wire [SLOT_COUNT-1:0]         victim_vec,
  input  wire                          victim_valid,
  input  wire [PAGE_W-1:0]             slot_tag,
  output logic [SLOT_COUNT-1:0]        slot_sel,
  output logic                         set_tag,
  output logic                         adjust_life,
  output logic [OFF_W-1:0]             word_offset,
  output logic                         ram_we,
  output cache_pkg::line_word_t        ram_wdata,
  output logic                         ram_merge,
  input  cache_pkg::line_word_t        ram_rdata,
  output logic                         cnt_clear,
  output logic                         cnt_step,
  input  wire [OFF_W-1:0]              cnt_index,
  input  wire                          cnt_last,
  output cache_pkg::mem_cmd_t          mem_cmd,
  input  wire                          mem_ack,
  input  wire [cache_pkg::DATA_W-1:0]  mem_rdata
);

  cache_pkg::ctrl_state_e state;
  logic [SLOT_COUNT-1:0]  slot_loaded;  // slot holds a filled page
  logic                   ack_seen;     // write-back word taken by memory
  logic                   host_ack;
  logic                   host_active;
  logic                   any_hit;
  logic                   need_wb;
  logic                   start_miss;
  logic                   wb_word_done;
  logic                   fill_taken;
  logic                   fill_word_done;
  logic                   bypass_taken;
  logic                   bypass_done;
  logic [PAGE_W-1:0]      host_page;

  assign host_active = host_req.read | host_req.write;
  assign host_page   = host_req.addr[cache_pkg::ADDR_W-1:OFF_W];
  assign any_hit     = |hit_vec;
  assign need_wb     = |(slot_loaded & slot_sel);  // old page must go back first
  assign waitrequest = host_active & ~host_ack;

  assign start_miss     = (state == cache_pkg::LOOKUP) & ~any_hit & victim_valid;
  assign wb_word_done   = (state == cache_pkg::WB_ISSUE) &
                          (~ram_rdata.dirty | (ack_seen & ~mem_ack));  // clean words skip
  assign fill_taken     = (state == cache_pkg::FILL_WAIT) & mem_cmd.req & mem_ack;
  assign fill_word_done = (state == cache_pkg::FILL_WAIT) & ~mem_cmd.req & ~mem_ack;
  assign bypass_taken   = (state == cache_pkg::BYPASS) & mem_cmd.req & mem_ack;
  assign bypass_done    = (state == cache_pkg::BYPASS) & ~mem_cmd.req & ~mem_ack;

  always_comb begin
    set_tag     = (start_miss & ~need_wb) | (wb_word_done & cnt_last);
    cnt_clear   = start_miss | (wb_word_done & cnt_last);
    cnt_step    = (wb_word_done | fill_word_done) & ~cnt_last;
    adjust_life = (state == cache_pkg::SERVE) | bypass_done;
    ram_merge   = (state == cache_pkg::SERVE);
    ram_we      = fill_taken | (ram_merge & host_req.write);
    ram_wdata   = fill_taken ? '{data: mem_rdata, dirty: 1'b0} : ram_rdata;
    case (state)
      cache_pkg::WB_READ, cache_pkg::WB_ISSUE,
      cache_pkg::FILL_ISSUE, cache_pkg::FILL_WAIT:
        word_offset = cnt_index + OFF_W'(cnt_step);  // look ahead so rdata follows the counter
      default:
        word_offset = host_req.addr[OFF_W-1:0];
    endcase
  end

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state       <= cache_pkg::IDLE;
      slot_sel    <= '0;
      slot_loaded <= '0;
      mem_cmd     <= '0;
      ack_seen    <= 1'b0;
      host_ack    <= 1'b0;
    end else begin
      if (set_tag) slot_loaded <= slot_loaded | slot_sel;
      case (state)
        cache_pkg::IDLE: begin
          if (host_active) begin
            slot_sel <= any_hit ? hit_vec : victim_vec;  // zero when no slot is free
            state    <= cache_pkg::LOOKUP;
          end
        end
        cache_pkg::LOOKUP: begin
          if (any_hit) begin
            state <= cache_pkg::SERVE;
          end else if (victim_valid) begin
            state <= need_wb ? cache_pkg::WB_READ : cache_pkg::FILL_ISSUE;
          end else begin
            // bypass writes store the whole word
            mem_cmd <= '{req: 1'b1, we: host_req.write, addr: host_req.addr,
                         wdata: host_req.writedata};
            state   <= cache_pkg::BYPASS;
          end
        end
        cache_pkg::SERVE: begin
          host_ack <= 1'b1;
          state    <= cache_pkg::DONE_WAIT;
        end
        cache_pkg::WB_READ: begin
          ack_seen <= 1'b0;
          state    <= cache_pkg::WB_ISSUE;
        end
        cache_pkg::WB_ISSUE: begin
          if (wb_word_done) begin
            ack_seen <= 1'b0;
            if (cnt_last) state <= cache_pkg::FILL_ISSUE;
          end else if (!ack_seen) begin
            if (!mem_cmd.req && !mem_ack) begin
              mem_cmd <= '{req: 1'b1, we: 1'b1, addr: {slot_tag, cnt_index},
                           wdata: ram_rdata.data};
            end else if (mem_cmd.req && mem_ack) begin
              mem_cmd.req <= 1'b0;
              ack_seen    <= 1'b1;
            end
          end
        end
        cache_pkg::FILL_ISSUE: begin
          mem_cmd <= '{req: 1'b1, we: 1'b0, addr: {host_page, cnt_index}, wdata: '0};
          state   <= cache_pkg::FILL_WAIT;
        end
        cache_pkg::FILL_WAIT: begin
          if (fill_taken) mem_cmd.req <= 1'b0;
          if (fill_word_done) begin
            state <= cnt_last ? cache_pkg::LOOKUP : cache_pkg::FILL_ISSUE;  // then hits
          end
        end
        cache_pkg::BYPASS: begin
          if (bypass_taken) mem_cmd.req <= 1'b0;
          if (bypass_done) begin
            host_ack <= 1'b1;
            state    <= cache_pkg::DONE_WAIT;
          end
        end
        cache_pkg::DONE_WAIT: begin
          if (!host_active) begin
            host_ack <= 1'b0;  // drops one cycle after the host lets go
            state    <= cache_pkg::IDLE;
          end
        end
        default: state <= cache_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == cache_pkg::SERVE) begin
      readdata <= ram_rdata.data;
    end else if (bypass_taken && !mem_cmd.we) begin
      readdata <= mem_rdata;
    end
  end

  // memory sees a steady command until it answers
  a_mem_cmd_stable: assert property (@(posedge clk) disable iff (!sys_rst_n)
    (mem_cmd.req && !mem_ack) |=> $stable(mem_cmd));

endmodule

`default_nettype wire

//--- design/cache_pkg.sv
`default_nettype none

package cache_pkg;

  localparam int ADDR_W = 16;  // host word address
  localparam int DATA_W = 32;
  localparam int BE_W   = 4;
  localparam int LIFE_W = 8;   // per-slot life counter

  // one host access, held stable while waitrequest is high
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              read;
    logic              write;
    logic [DATA_W-1:0] writedata;
    logic [BE_W-1:0]   byteenable;
  } host_req_t;

  // single-word memory command, req is a level held until mem_ack
  typedef struct packed {
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mem_cmd_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              dirty;  // word differs from memory
  } line_word_t;

  typedef enum logic [3:0] {
    IDLE,
    LOOKUP,
    SERVE,
    WB_READ,
    WB_ISSUE,
    FILL_ISSUE,
    FILL_WAIT,
    BYPASS,
    DONE_WAIT
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- design/line_data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module line_data_ram #(
  parameter int SLOT_COUNT = 4,
  parameter int LINE_WORDS = 16,
  localparam int OFF_W  = $clog2(LINE_WORDS),
  localparam int SLOT_W = (SLOT_COUNT > 1) ? $clog2(SLOT_COUNT) : 1
) (
  input  wire                          clk,
  input  wire [SLOT_COUNT-1:0]         slot_sel,
  input  wire [OFF_W-1:0]              word_offset,
  input  wire                          we,
  input  cache_pkg::line_word_t        wdata,
  input  wire                          merge,
  input  wire [cache_pkg::BE_W-1:0]    byteenable,
  input  wire [cache_pkg::DATA_W-1:0]  writedata,
  output cache_pkg::line_word_t        rdata
);

  localparam int DEPTH = SLOT_COUNT * LINE_WORDS;

  cache_pkg::line_word_t mem [DEPTH];
  cache_pkg::line_word_t merged;
  logic [SLOT_W-1:0]     slot_idx;
  logic [SLOT_W+OFF_W-1:0] addr;

  // one-hot slot select to index
  always_comb begin
    slot_idx = '0;
    for (int i = 0; i < SLOT_COUNT; i++) begin
      if (slot_sel[i]) slot_idx = SLOT_W'(i);
    end
  end

  assign addr = {slot_idx, word_offset};  // LINE_WORDS is a power of two

  // host bytes over the stored word
  always_comb begin
    merged       = wdata;
    merged.dirty = wdata.dirty | merge;
    for (int b = 0; b < cache_pkg::BE_W; b++) begin
      if (merge && byteenable[b]) merged.data[8*b +: 8] = writedata[8*b +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (we) mem[addr] <= merged;
    rdata <= mem[addr];  // registered read
  end

endmodule

`default_nettype wire

//--- design/line_word_counter.sv
`timescale 1ns/1ps
`default_nettype none

module line_word_counter #(
  parameter int LINE_WORDS = 16,
  localparam int OFF_W = $clog2(LINE_WORDS)
) (
  input  wire              clk,
  input  wire              sys_rst_n,
  input  wire              clear,
  input  wire              step,
  output logic [OFF_W-1:0] index,
  output logic             last
);

  assign last = (index == OFF_W'(LINE_WORDS - 1));

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      index <= '0;
    end else if (clear) begin
      index <= '0;  // restart at first word of the line
    end else if (step) begin
      index <= index + OFF_W'(1);
    end
  end

  // the controller ends its walk at the last word
  a_no_step_past_last: assert property (@(posedge clk) disable iff (!sys_rst_n)
    !(step && last && !clear));

endmodule

`default_nettype wire

//--- design/page_cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module page_cache_top #(
  parameter int SLOT_COUNT = 4,
  parameter int LINE_WORDS = 16,
  parameter int LIFE_BOOST = 8
) (
  input  wire                               clk,
  input  wire                               sys_rst_n,
  input  cache_pkg::host_req_t              host_req,
  output logic [cache_pkg::DATA_W-1:0]      readdata,
  output logic                              waitrequest,
  output cache_pkg::mem_cmd_t               mem_cmd,
  input  wire                               mem_ack,
  input  wire [cache_pkg::DATA_W-1:0]       mem_rdata
);

  localparam int OFF_W  = $clog2(LINE_WORDS);
  localparam int PAGE_W = cache_pkg::ADDR_W - OFF_W;

  logic [SLOT_COUNT-1:0]  hit_vec;
  logic [SLOT_COUNT-1:0]  victim_vec;
  logic                   victim_valid;
  logic [PAGE_W-1:0]      slot_tag;
  logic [SLOT_COUNT-1:0]  slot_sel;
  logic                   set_tag;
  logic                   adjust_life;
  logic [OFF_W-1:0]       word_offset;
  logic                   ram_we;
  logic                   ram_merge;
  cache_pkg::line_word_t  ram_wdata;
  cache_pkg::line_word_t  ram_rdata;
  logic                   cnt_clear;
  logic                   cnt_step;
  logic [OFF_W-1:0]       cnt_index;
  logic                   cnt_last;

  cache_ctrl_fsm #(
    .SLOT_COUNT (SLOT_COUNT),
    .LINE_WORDS (LINE_WORDS)
  ) ctrl_inst (
    .clk          (clk),
    .sys_rst_n    (sys_rst_n),
    .host_req     (host_req),
    .readdata     (readdata),
    .waitrequest  (waitrequest),
    .hit_vec      (hit_vec),
    .victim_vec   (victim_vec),
    .victim_valid (victim_valid),
    .slot_tag     (slot_tag),
    .slot_sel     (slot_sel),
    .set_tag      (set_tag),
    .adjust_life  (adjust_life),
    .word_offset  (word_offset),
    .ram_we       (ram_we),
    .ram_wdata    (ram_wdata),
    .ram_merge    (ram_merge),
    .ram_rdata    (ram_rdata),
    .cnt_clear    (cnt_clear),
    .cnt_step     (cnt_step),
    .cnt_index    (cnt_index),
    .cnt_last     (cnt_last),
    .mem_cmd      (mem_cmd),
    .mem_ack      (mem_ack),
    .mem_rdata    (mem_rdata)
  );

  line_word_counter #(
    .LINE_WORDS (LINE_WORDS)
  ) counter_inst (
    .clk       (clk),
    .sys_rst_n (sys_rst_n),
    .clear     (cnt_clear),
    .step      (cnt_step),
    .index     (cnt_index),
    .last      (cnt_last)
  );

  slot_tag_store #(
    .SLOT_COUNT (SLOT_COUNT),
    .LINE_WORDS (LINE_WORDS),
    .LIFE_BOOST (LIFE_BOOST)
  ) tags_inst (
    .clk          (clk),
    .sys_rst_n    (sys_rst_n),
    .page         (host_req.addr[cache_pkg::ADDR_W-1:OFF_W]),
    .slot_sel     (slot_sel),
    .set_tag      (set_tag),
    .adjust_life  (adjust_life),
    .hit_vec      (hit_vec),
    .victim_vec   (victim_vec),
    .victim_valid (victim_valid),
    .slot_tag     (slot_tag)
  );

  line_data_ram #(
    .SLOT_COUNT (SLOT_COUNT),
    .LINE_WORDS (LINE_WORDS)
  ) data_inst (
    .clk         (clk),
    .slot_sel    (slot_sel),
    .word_offset (word_offset),
    .we          (ram_we),
    .wdata       (ram_wdata),
    .merge       (ram_merge),
    .byteenable  (host_req.byteenable),
    .writedata   (host_req.writedata),
    .rdata       (ram_rdata)
  );

endmodule

`default_nettype wire

//--- design/slot_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module slot_tag_store #(
  parameter int SLOT_COUNT = 4,
  parameter int LINE_WORDS = 16,
  parameter int LIFE_BOOST = 8,
  localparam int OFF_W  = $clog2(LINE_WORDS),
  localparam int PAGE_W = cache_pkg::ADDR_W - OFF_W
) (
  input  wire                   clk,
  input  wire                   sys_rst_n,
  input  wire [PAGE_W-1:0]      page,
  input  wire [SLOT_COUNT-1:0]  slot_sel,
  input  wire                   set_tag,
  input  wire                   adjust_life,
  output logic [SLOT_COUNT-1:0] hit_vec,
  output logic [SLOT_COUNT-1:0] victim_vec,
  output logic                  victim_valid,
  output logic [PAGE_W-1:0]     slot_tag
);

  localparam logic [cache_pkg::LIFE_W-1:0] BOOST    = cache_pkg::LIFE_W'(LIFE_BOOST);
  localparam logic [cache_pkg::LIFE_W-1:0] LIFE_MAX = '1;
  localparam logic [cache_pkg::LIFE_W-1:0] HEADROOM = LIFE_MAX - BOOST;  // above this saturate

  logic [PAGE_W-1:0]           tag [SLOT_COUNT];
  logic [cache_pkg::LIFE_W-1:0] life [SLOT_COUNT];
  logic [SLOT_COUNT-1:0]       invalid;

  always_comb begin
    hit_vec  = '0;
    slot_tag = '0;
    for (int i = 0; i < SLOT_COUNT; i++) begin
      hit_vec[i] = ~invalid[i] & (tag[i] == page);
      if (slot_sel[i]) slot_tag = slot_tag | tag[i];
    end
  end

  // lowest free slot wins
  always_comb begin
    victim_vec = '0;
    for (int i = SLOT_COUNT - 1; i >= 0; i--) begin
      if (life[i] == '0) begin
        victim_vec    = '0;
        victim_vec[i] = 1'b1;
      end
    end
  end

  assign victim_valid = |victim_vec;

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      invalid <= '1;
      for (int i = 0; i < SLOT_COUNT; i++) life[i] <= '0;
    end else begin
      for (int i = 0; i < SLOT_COUNT; i++) begin
        if (set_tag && slot_sel[i]) begin
          invalid[i] <= 1'b0;
          life[i]    <= BOOST;  // new page starts with one boost
        end else if (adjust_life) begin
          if (slot_sel[i]) begin
            life[i] <= (life[i] > HEADROOM) ? LIFE_MAX : life[i] + BOOST;
          end else if (life[i] != '0) begin
            life[i] <= life[i] - 1'b1;  // others age
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < SLOT_COUNT; i++) begin
      if (set_tag && slot_sel[i]) tag[i] <= page;
    end
  end

  // two slots never hold the same page
  a_hit_onehot: assert property (@(posedge clk) disable iff (!sys_rst_n)
    $onehot0(hit_vec));

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the page cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module page_cache_tb -f build.f -o page_cache_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/page_cache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
  echo "simulation reported errors"
  exit 1
fi
if ! grep -q "Done: no errors" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

//--- verification/cache_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cache_checker (
  input  wire                         clk,
  input  wire                         sys_rst_n,
  input  cache_pkg::host_req_t        host_req,
  input  wire [cache_pkg::DATA_W-1:0] readdata,
  input  wire                         waitrequest,
  input  cache_pkg::mem_cmd_t         mem_cmd,
  input  wire                         mem_ack,
  input  int                          test_num,
  input  wire                         test_end,
  input  wire                         check_idle,
  input  wire                         check_hit_latency,
  input  wire                         expect_bypass,
  output int                          error_count,
  output int                          check_count
);

  localparam int ADDR_SPAN = 1 << cache_pkg::ADDR_W;
  localparam int HIT_WAIT  = 3;  // IDLE, LOOKUP, SERVE before ack is seen

  logic [cache_pkg::DATA_W-1:0] shadow [0:ADDR_SPAN-1];
  int wait_cycles;
  int access_txns;  // memory transactions since the last host completion
  int errors_before;

  // enabled host bytes replace the stored ones
  function automatic logic [cache_pkg::DATA_W-1:0] merge_bytes(
    input logic [cache_pkg::DATA_W-1:0] old_word,
    input logic [cache_pkg::DATA_W-1:0] new_word,
    input logic [cache_pkg::BE_W-1:0]   be
  );
    logic [cache_pkg::DATA_W-1:0] result;
    result = old_word;
    for (int b = 0; b < cache_pkg::BE_W; b++) begin
      if (be[b]) result[8*b +: 8] = new_word[8*b +: 8];
    end
    return result;
  endfunction

  function automatic string test_name(input int num);
    case (num)
      1: return "idle after reset";
      2: return "initial pattern and hit latency";
      3: return "write then read with byte enables";
      4: return "eviction and write-back";
      5: return "bypass when no slot is free";
      default: return "unnamed";
    endcase
  endfunction

  task automatic report_mismatch(input string msg);
    error_count++;
    $display("FAILED t=%0t: %s", $time, msg);
  endtask

  task automatic report_problem(input string msg);
    error_count++;
    $display("error at t=%0t: %s", $time, msg);
  endtask

  task automatic check_mem_write();
    logic [cache_pkg::DATA_W-1:0] expected;
    expected = shadow[mem_cmd.addr];
    // a bypass write carries the host word itself
    if (host_req.write && mem_cmd.addr == host_req.addr) begin
      expected = merge_bytes(expected, host_req.writedata, host_req.byteenable);
    end
    check_count++;
    if (mem_cmd.wdata !== expected) begin
      report_mismatch($sformatf("memory write %h carries %h, expected %h",
                                mem_cmd.addr, mem_cmd.wdata, expected));
    end
  endtask

  task automatic check_completion();
    logic [cache_pkg::DATA_W-1:0] expected;
    expected = shadow[host_req.addr];
    if (host_req.read) begin
      check_count++;
      if (readdata !== expected) begin
        report_mismatch($sformatf("read %h returned %h, expected %h",
                                  host_req.addr, readdata, expected));
      end
    end else begin
      shadow[host_req.addr] = merge_bytes(expected, host_req.writedata, host_req.byteenable);
    end
    if (check_hit_latency) begin
      check_count++;
      if (wait_cycles != HIT_WAIT) begin
        report_problem($sformatf("hit held waitrequest for %0d cycles instead of %0d",
                                 wait_cycles, HIT_WAIT));
      end
    end
    if (expect_bypass) begin
      check_count++;
      if (access_txns != 1) begin
        report_problem($sformatf("bypass used %0d memory transactions instead of one",
                                 access_txns));
      end
    end
  endtask

  always @(posedge clk) begin
    if (!sys_rst_n) begin
      error_count   = 0;
      check_count   = 0;
      wait_cycles   = 0;
      access_txns   = 0;
      errors_before = 0;
      for (int a = 0; a < ADDR_SPAN; a++) begin
        shadow[a] = 32'(a) ^ 32'hA5A5_0000;  // power-on memory pattern
      end
    end else begin
      if (check_idle && (waitrequest || mem_cmd.req)) begin
        report_problem("DUT is busy although no host request is pending");
      end
      if (mem_cmd.req && mem_ack) begin
        access_txns++;
        if (mem_cmd.we) check_mem_write();
      end
      if ((host_req.read || host_req.write) && waitrequest) begin
        wait_cycles++;
      end else if (host_req.read || host_req.write) begin
        check_completion();  // transfer ends on this edge
        wait_cycles = 0;
        access_txns = 0;
      end
      if (test_end) begin
        $display("test %0d %s: %s, %0d errors", test_num, test_name(test_num),
                 (error_count == errors_before) ? "passed" : "failed",
                 error_count - errors_before);
        errors_before = error_count;
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/page_cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module page_cache_tb;

  localparam int SLOT_COUNT  = 4;
  localparam int LINE_WORDS  = 16;
  localparam int LIFE_BOOST  = 8;
  localparam int BASE_PAGE   = 'h100;
  localparam int WR_PAIRS    = 6;
  localparam int AGING_HITS  = 60;   // ages two loaded slots down to zero
  localparam int ACCESSES    = 2 + 2 * WR_PAIRS + 18 + AGING_HITS + 12 + 11;
  localparam int MISS_CYCLES = 300;  // full write-back and fill, slowest memory
  localparam longint WATCHDOG_NS = longint'(ACCESSES + 2) * MISS_CYCLES * 20;

  logic                         clk;
  logic                         sys_rst_n;
  cache_pkg::host_req_t         host_req;
  logic [cache_pkg::DATA_W-1:0] readdata;
  logic                         waitrequest;
  cache_pkg::mem_cmd_t          mem_cmd;
  logic                         mem_ack;
  logic [cache_pkg::DATA_W-1:0] mem_rdata;
  int                           test_num;
  logic                         test_end;
  logic                         check_idle;
  logic                         check_hit_latency;
  logic                         expect_bypass;
  int                           error_count;
  int                           check_count;
  int                           tb_errors;
  logic [31:0]                  lfsr = 32'h321f;
  logic [cache_pkg::DATA_W-1:0] mem_model [0:(1 << cache_pkg::ADDR_W)-1];

  tb_clock_gen #(.PERIOD_NS(20)) clock_inst (.clk(clk));

  page_cache_top #(
    .SLOT_COUNT (SLOT_COUNT),
    .LINE_WORDS (LINE_WORDS),
    .LIFE_BOOST (LIFE_BOOST)
  ) page_cache_inst (
    .clk         (clk),
    .sys_rst_n   (sys_rst_n),
    .host_req    (host_req),
    .readdata    (readdata),
    .waitrequest (waitrequest),
    .mem_cmd     (mem_cmd),
    .mem_ack     (mem_ack),
    .mem_rdata   (mem_rdata)
  );

  cache_checker checker_inst (
    .clk               (clk),
    .sys_rst_n         (sys_rst_n),
    .host_req          (host_req),
    .readdata          (readdata),
    .waitrequest       (waitrequest),
    .mem_cmd           (mem_cmd),
    .mem_ack           (mem_ack),
    .test_num          (test_num),
    .test_end          (test_end),
    .check_idle        (check_idle),
    .check_hit_latency (check_hit_latency),
    .expect_bypass     (expect_bypass),
    .error_count       (error_count),
    .check_count       (check_count)
  );

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr  = lfsr_next(lfsr);
      value = {value[30:0], lfsr[0]};  // one step per bit
    end
  endtask

  function automatic logic [cache_pkg::ADDR_W-1:0] page_addr(input int page, input int offset);
    return cache_pkg::ADDR_W'(page * LINE_WORDS + offset);
  endfunction

  task automatic host_access(input logic is_write, input logic [cache_pkg::ADDR_W-1:0] addr,
                             input logic [31:0] data, input logic [3:0] be);
    int waited;
    @(negedge clk);
    host_req = '{addr: addr, read: !is_write, write: is_write, writedata: data, byteenable: be};
    waited = 0;
    do begin
      @(negedge clk);  // waitrequest settled
      waited++;
    end while (waitrequest && waited < MISS_CYCLES);
    if (waitrequest) begin
      tb_errors++;
      $display("no acknowledge for access to %h within %0d cycles", addr, MISS_CYCLES);
    end
    @(negedge clk);
    host_req = '0;  // one idle cycle before the next request
  endtask

  task automatic write_random(input logic [cache_pkg::ADDR_W-1:0] addr);
    logic [31:0] data;
    logic [31:0] be;
    draw_bits(32, data);
    draw_bits(4, be);
    host_access(1'b1, addr, data, be[3:0]);
  endtask

  task automatic read_word(input logic [cache_pkg::ADDR_W-1:0] addr);
    host_access(1'b0, addr, '0, '0);
  endtask

  task automatic finish_test();
    @(negedge clk);
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  // four-phase responder, 0 to 3 cycles before ack
  initial begin : memory_model
    logic [31:0]         delay;
    cache_pkg::mem_cmd_t cmd;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    for (int a = 0; a < (1 << cache_pkg::ADDR_W); a++) begin
      mem_model[a] = 32'(a) ^ 32'hA5A5_0000;
    end
    forever begin
      @(posedge clk);
      if (sys_rst_n && mem_cmd.req) begin
        draw_bits(2, delay);
        repeat (delay) @(posedge clk);
        @(negedge clk);
        cmd = mem_cmd;
        if (cmd.we) begin
          mem_model[cmd.addr] = cmd.wdata;
        end else begin
          mem_rdata = mem_model[cmd.addr];
        end
        mem_ack = 1'b1;
        do begin
          @(posedge clk);
        end while (mem_cmd.req);
        @(negedge clk);
        mem_ack = 1'b0;
      end
    end
  end

  initial begin : stimulus
    logic [31:0] data;
    host_req          = '0;
    sys_rst_n         = 1'b0;
    test_num          = 0;
    test_end          = 1'b0;
    check_idle        = 1'b0;
    check_hit_latency = 1'b0;
    expect_bypass     = 1'b0;
    tb_errors         = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    sys_rst_n = 1'b1;

    test_num   = 1;
    check_idle = 1'b1;
    repeat (20) @(negedge clk);
    check_idle = 1'b0;
    finish_test();

    test_num = 2;
    read_word(page_addr(BASE_PAGE, 3));  // miss, fills slot 0
    check_hit_latency = 1'b1;
    read_word(page_addr(BASE_PAGE, 3));
    check_hit_latency = 1'b0;
    finish_test();

    test_num = 3;
    for (int i = 0; i < WR_PAIRS; i++) begin
      write_random(page_addr(BASE_PAGE, i));
      read_word(page_addr(BASE_PAGE, i));
    end
    finish_test();

    // dirty words 2, 7 and 12 with clean words between
    test_num = 4;
    for (int p = 1; p <= 3; p++) begin
      for (int k = 0; k < 3; k++) write_random(page_addr(BASE_PAGE + p, 5 * k + 2));
      for (int k = 0; k < 3; k++) read_word(page_addr(BASE_PAGE + p, 5 * k + 2));
    end
    repeat (AGING_HITS) read_word(page_addr(BASE_PAGE + 3, 2));
    write_random(page_addr(BASE_PAGE + 4, 4));  // evicts page 1
    read_word(page_addr(BASE_PAGE + 4, 4));
    write_random(page_addr(BASE_PAGE + 5, 11));  // evicts page 2
    read_word(page_addr(BASE_PAGE + 5, 11));
    for (int p = 1; p <= 2; p++) begin
      for (int k = 0; k < 3; k++) read_word(page_addr(BASE_PAGE + p, 5 * k + 2));
    end
    read_word(page_addr(BASE_PAGE, 0));
    read_word(page_addr(BASE_PAGE, 5));
    finish_test();

    test_num = 5;
    for (int r = 0; r < 2; r++) begin
      read_word(page_addr(BASE_PAGE, 0));
      read_word(page_addr(BASE_PAGE + 3, 2));
      read_word(page_addr(BASE_PAGE + 4, 4));
      read_word(page_addr(BASE_PAGE + 5, 11));
    end
    expect_bypass = 1'b1;
    read_word(page_addr(BASE_PAGE + 6, 1));
    draw_bits(32, data);
    host_access(1'b1, page_addr(BASE_PAGE + 6, 1), data, 4'hF);  // bypass stores whole word
    read_word(page_addr(BASE_PAGE + 6, 1));
    expect_bypass = 1'b0;
    finish_test();

    @(negedge clk);
    $display("summary: %0d checks, %0d errors", check_count, error_count + tb_errors);
    if (error_count + tb_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the DUT stopped responding", WATCHDOG_NS);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;  // even duty cycle
  end

endmodule

`default_nettype wire
